/* rdmx_shim.f */
+incdir+src
src/rdmx_pkg.sv
src/rdmx_geometry.sv
src/rdmx_md_capture.sv
src/rdmx_frame_sequencer.sv
src/rdmx_ring_ptrs.sv
src/rdmx_write_mux.sv
src/rdmx_shim.sv
tests/rdmx_shim_tb.sv

/* Bender.yml */
package:
  name: rdmx_shim

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/rdmx_pkg.sv
      - src/rdmx_geometry.sv
      - src/rdmx_md_capture.sv
      - src/rdmx_frame_sequencer.sv
      - src/rdmx_ring_ptrs.sv
      - src/rdmx_write_mux.sv
      - src/rdmx_shim.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/rdmx_shim_tb.sv

/* tests/rdmx_shim_tb.sv */
// RDMA write shim testbench
`include "rdmx_macros.svh"

module rdmx_shim_tb;

    import rdmx_pkg::*;

    // Stream geometry, two beats per packet and four packets per half-frame
    localparam int PKT_SIZE    = 128;
    localparam int FRAME_SIZE  = 1024;
    localparam int BEATS       = PKT_SIZE / (`RDMX_DATA_W / 8);
    localparam int PKTS        = FRAME_SIZE / PKT_SIZE / 2;
    localparam int NUM_FRAMES  = 6;
    localparam int FD_BEATS    = NUM_FRAMES * PKTS * BEATS;
    localparam int MD_BEATS    = NUM_FRAMES * 2;
    localparam int TOTAL_BEATS = NUM_FRAMES * (PKTS * BEATS + 3);
    localparam int CYCLE_LIMIT = 10 * TOTAL_BEATS;
    localparam int MD_HOLD     = 60;
    // Small rings, five packet slots and three record slots
    localparam logic [63:0] FD_RING_ADDR = 64'h0000_1000_0000_0000;
    localparam logic [63:0] FD_RING_SIZE = 64'd640;
    localparam logic [63:0] MD_RING_ADDR = 64'h0000_2000_0000_0000;
    localparam logic [63:0] MD_RING_SIZE = 64'd384;
    localparam logic [63:0] FC_ADDR      = 64'h0000_3000_0000_0040;
    localparam logic [31:0] SEED         = 32'hace0_e9f3;

    typedef enum int {PH_FD, PH_MD1, PH_MD2, PH_FC} phase_e;

    logic                    clk;
    logic                    resetn;
    rdmx_cfg_t               cfg;
    logic [`RDMX_DATA_W-1:0] fd_data;
    logic                    fd_valid;
    logic                    fd_last;
    logic                    fd_ready;
    logic [`RDMX_DATA_W-1:0] md_data;
    logic                    md_valid;
    logic                    md_ready;
    rdmx_aw_t                aw;
    rdmx_w_beat_t            w;
    logic                    w_ready;
    logic [`RDMX_CNT_W-1:0]  frame_count;

    // Reference model state
    logic [`RDMX_DATA_W-1:0] fd_q[$];
    logic [`RDMX_DATA_W-1:0] md_q[$];
    phase_e                  ref_phase;
    int                      ref_beat;
    int                      ref_pkt;
    int                      ref_frame;
    logic [63:0]             ref_fd_off;
    logic [63:0]             ref_md_off;
    // Stimulus bookkeeping
    int                      fd_sent;
    int                      md_sent;
    int                      md_taken;
    int                      md_wait;
    logic                    fd_take_s;
    logic                    md_take_s;
    logic                    fc_pending;
    logic                    done;
    int                      cycles;
    int                      mismatches;
    int                      errors;

    rdmx_shim dut0 (
        .clk(clk), .resetn(resetn), .cfg(cfg),
        .fd_data(fd_data), .fd_valid(fd_valid), .fd_last(fd_last), .fd_ready(fd_ready),
        .md_data(md_data), .md_valid(md_valid), .md_ready(md_ready),
        .aw(aw), .w(w), .w_ready(w_ready), .frame_count(frame_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic logic [`RDMX_DATA_W-1:0] random_beat();
        logic [`RDMX_DATA_W-1:0] d;
        for (int i = 0; i < `RDMX_DATA_W / 32; i++) begin
            d[i*32 +: 32] = $urandom;
        end
        return d;
    endfunction

    // Next offset, back to zero when it would not fit in the ring
    function automatic logic [63:0] ring_step(logic [63:0] off, logic [63:0] step,
                                              logic [63:0] size);
        return (off + step < size) ? off + step : 64'd0;
    endfunction

    // Expected write beat for the current model position
    function automatic rdmx_w_beat_t predict_w_beat();
        rdmx_w_beat_t b;
        b       = '0;
        b.valid = 1'b1;
        b.strb  = '1;
        case (ref_phase)
            PH_FD: begin
                if (fd_q.size() > 0) b.data = fd_q[0];
                b.last = (ref_beat == BEATS - 1);
            end
            PH_MD1: if (md_q.size() > 0) b.data = md_q[0];
            PH_MD2: begin
                if (md_q.size() > 0) b.data = md_q[0];
                b.last = 1'b1;
            end
            default: begin
                b.data[31:0] = 32'(ref_frame + 1);
                b.strb       = '0;
                b.strb[3:0]  = 4'hF;
                b.last       = 1'b1;
            end
        endcase
        return b;
    endfunction

    // Expected address strobe, only on the first beat of a burst
    function automatic rdmx_aw_t predict_aw();
        rdmx_aw_t a;
        a      = '0;
        a.user = 32'(ref_frame + 1);
        case (ref_phase)
            PH_FD: begin
                a.addr  = FD_RING_ADDR + ref_fd_off;
                a.len   = 8'(BEATS - 1);
                a.valid = (ref_beat == 0);
            end
            PH_MD1: begin
                a.addr  = MD_RING_ADDR + ref_md_off;
                a.len   = 8'd1;
                a.valid = 1'b1;
            end
            PH_MD2: a.valid = 1'b0;
            default: begin
                a.addr  = FC_ADDR;
                a.valid = 1'b1;
            end
        endcase
        return a;
    endfunction

    // Step the model past one transferred write beat
    task automatic advance_model();
        case (ref_phase)
            PH_FD: begin
                if (fd_q.size() > 0) fd_q.delete(0);
                if (ref_beat == BEATS - 1) begin
                    ref_beat   = 0;
                    ref_fd_off = ring_step(ref_fd_off, PKT_SIZE, FD_RING_SIZE);
                    if (ref_pkt == PKTS - 1) begin
                        ref_pkt   = 0;
                        ref_phase = PH_MD1;
                    end else begin
                        ref_pkt++;
                    end
                end else begin
                    ref_beat++;
                end
            end
            PH_MD1: begin
                if (md_q.size() > 0) md_q.delete(0);
                ref_phase = PH_MD2;
            end
            PH_MD2: begin
                if (md_q.size() > 0) md_q.delete(0);
                ref_md_off = ring_step(ref_md_off, `RDMX_MD_BYTES, MD_RING_SIZE);
                ref_phase  = PH_FC;
            end
            default: begin
                ref_frame++;
                fc_pending = 1'b1;
                ref_phase  = PH_FD;
                if (ref_frame == NUM_FRAMES) done = 1'b1;
            end
        endcase
    endtask

    // ----------------------------------------
    // Checker
    // ----------------------------------------
    task automatic report_mismatch(string test, string field,
                                   logic [`RDMX_DATA_W-1:0] exp_v,
                                   logic [`RDMX_DATA_W-1:0] act_v);
        mismatches++;
        $display("Mismatch %s %s expected %0h actual %0h", test, field, exp_v, act_v);
    endtask

    task automatic report_error(string msg);
        errors++;
        $display("Error: %s at time %0t", msg, $time);
    endtask

    task automatic check_write();
        rdmx_w_beat_t exp_w;
        rdmx_aw_t     exp_aw;
        string        test;
        exp_w  = predict_w_beat();
        exp_aw = predict_aw();
        case (ref_phase)
            PH_FD:   test = "frame_data";
            PH_FC:   test = "frame_counter";
            default: test = "metadata";
        endcase
        if (ref_phase == PH_FD && fd_q.size() == 0)
            report_error("frame-data write with no stream beat outstanding");
        if ((ref_phase == PH_MD1 || ref_phase == PH_MD2) && md_taken < 2 * ref_frame + 2)
            report_error("metadata written before both beats were supplied");
        if (w.data !== exp_w.data) report_mismatch(test, "w.data", exp_w.data, w.data);
        if (w.strb !== exp_w.strb) report_mismatch(test, "w.strb", exp_w.strb, w.strb);
        if (w.last !== exp_w.last) report_mismatch(test, "w.last", exp_w.last, w.last);
        if (aw.valid !== exp_aw.valid)
            report_mismatch(test, "aw.valid", exp_aw.valid, aw.valid);
        if (exp_aw.valid) begin
            if (aw.addr !== exp_aw.addr) report_mismatch(test, "aw.addr", exp_aw.addr, aw.addr);
            if (aw.len !== exp_aw.len) report_mismatch(test, "aw.len", exp_aw.len, aw.len);
            if (aw.user !== exp_aw.user) report_mismatch(test, "aw.user", exp_aw.user, aw.user);
        end
        if (ref_phase == PH_FC && frame_count !== ref_frame)
            report_mismatch(test, "frame_count", ref_frame, frame_count);
    endtask

    // Outputs are settled half a cycle after the drive point
    always @(negedge clk) begin
        fd_take_s = fd_valid && fd_ready;
        md_take_s = md_valid && md_ready;
        if (resetn) begin
            if (md_take_s) md_taken++;
            // Counter moves one cycle after its beat
            if (fc_pending) begin
                fc_pending = 1'b0;
                if (frame_count !== ref_frame)
                    report_mismatch("frame_counter", "frame_count", ref_frame, frame_count);
            end
            if (w.valid && w_ready) begin
                check_write();
                advance_model();
            end else if (aw.valid) begin
                report_error("address strobe without a write beat");
            end
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic drive_inputs();
        w_ready = ($urandom_range(3) != 0);
        // Retire beats accepted at the last edge
        if (fd_take_s) fd_valid = 1'b0;
        if (md_take_s) md_valid = 1'b0;
        // Last flag on the final beat of each packet
        if (!fd_valid && fd_sent < FD_BEATS && $urandom_range(3) != 0) begin
            fd_data  = random_beat();
            fd_last  = (fd_sent % BEATS == BEATS - 1);
            fd_valid = 1'b1;
            fd_q.push_back(fd_data);
            fd_sent++;
        end
        // Third record held back for a while
        if (md_wait > 0) begin
            md_wait--;
        end else if (!md_valid && md_sent < MD_BEATS && $urandom_range(1) == 0) begin
            md_data  = random_beat();
            md_valid = 1'b1;
            md_q.push_back(md_data);
            md_sent++;
            if (md_sent == 4) md_wait = MD_HOLD;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        resetn           = 1'b0;
        cfg              = '0;
        cfg.pkt_size     = 16'(PKT_SIZE);
        cfg.frame_size   = 32'(FRAME_SIZE);
        cfg.fd_ring_addr = FD_RING_ADDR;
        cfg.fd_ring_size = FD_RING_SIZE;
        cfg.md_ring_addr = MD_RING_ADDR;
        cfg.md_ring_size = MD_RING_SIZE;
        cfg.fc_addr      = FC_ADDR;
        fd_data          = '0;
        fd_valid         = 1'b0;
        fd_last          = 1'b0;
        md_data          = '0;
        md_valid         = 1'b0;
        w_ready          = 1'b0;
        ref_phase        = PH_FD;
        ref_beat         = 0;
        ref_pkt          = 0;
        ref_frame        = 0;
        ref_fd_off       = '0;
        ref_md_off       = '0;
        fd_sent          = 0;
        md_sent          = 0;
        md_taken         = 0;
        md_wait          = 0;
        fd_take_s        = 1'b0;
        md_take_s        = 1'b0;
        fc_pending       = 1'b0;
        done             = 1'b0;
        cycles           = 0;
        mismatches       = 0;
        errors           = 0;
        // Handshake outputs stay quiet while reset is held
        repeat (16) begin
            @(posedge clk);
            #1;
            if (fd_ready !== 1'b0 || md_ready !== 1'b0 ||
                w.valid !== 1'b0 || aw.valid !== 1'b0)
                report_error("handshake output active during reset");
        end
        resetn = 1'b1;
        while (!done && cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            #1;
            drive_inputs();
            cycles++;
        end
        if (!done) report_error("timeout, six frames were not written within the cycle limit");
        // Room for the last counter update check
        repeat (2) @(negedge clk);
        $display("Run ended: %0d frames, %0d mismatches, %0d other errors",
                 ref_frame, mismatches, errors);
        if (mismatches == 0 && errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* src/rdmx_shim.sv */
// RDMA write shim top
`include "rdmx_macros.svh"

module rdmx_shim (
    input  logic                    clk,
    input  logic                    resetn,
    input  rdmx_pkg::rdmx_cfg_t     cfg,
    // Frame-data stream
    input  logic [`RDMX_DATA_W-1:0] fd_data,
    input  logic                    fd_valid,
    input  logic                    fd_last,
    output logic                    fd_ready,
    // Metadata stream
    input  logic [`RDMX_DATA_W-1:0] md_data,
    input  logic                    md_valid,
    output logic                    md_ready,
    // Memory-mapped write side
    output rdmx_pkg::rdmx_aw_t      aw,
    output rdmx_pkg::rdmx_w_beat_t  w,
    input  logic                    w_ready,
    output logic [`RDMX_CNT_W-1:0]  frame_count
);

    import rdmx_pkg::*;

    rdmx_geom_t              geom;
    rdmx_mode_e              mode;
    logic [`RDMX_DATA_W-1:0] md_beat0;
    logic [`RDMX_DATA_W-1:0] md_beat1;
    logic                    md_full;
    logic                    md_release;
    logic                    first_beat;
    logic                    pkt_done;
    logic                    md_done;
    logic                    w_fire;
    logic [`RDMX_ADDR_W-1:0] fd_off;
    logic [`RDMX_ADDR_W-1:0] md_off;

    // Side stages
    rdmx_geometry u_geometry (
        .clk(clk), .resetn(resetn), .cfg(cfg), .geom(geom)
    );

    rdmx_md_capture u_md_capture (
        .clk(clk), .resetn(resetn),
        .md_data(md_data), .md_valid(md_valid), .md_ready(md_ready),
        .md_release(md_release),
        .md_beat0(md_beat0), .md_beat1(md_beat1), .md_full(md_full)
    );

    // Frame FSM, sees w.last after the mux
    rdmx_frame_sequencer u_sequencer (
        .clk(clk), .resetn(resetn), .geom(geom),
        .w_fire(w_fire), .w_last(w.last), .md_full(md_full),
        .mode(mode), .first_beat(first_beat), .md_release(md_release),
        .pkt_done(pkt_done), .md_done(md_done), .frame_count(frame_count)
    );

    rdmx_ring_ptrs u_ring_ptrs (
        .clk(clk), .resetn(resetn), .cfg(cfg),
        .pkt_done(pkt_done), .md_done(md_done),
        .fd_off(fd_off), .md_off(md_off)
    );

    // Output stage, fully combinational
    rdmx_write_mux u_write_mux (
        .cfg(cfg), .mode(mode), .first_beat(first_beat),
        .frame_count(frame_count), .fd_off(fd_off), .md_off(md_off),
        .md_full(md_full), .md_beat0(md_beat0), .md_beat1(md_beat1),
        .fd_data(fd_data), .fd_valid(fd_valid), .fd_last(fd_last),
        .geom(geom), .w_ready(w_ready),
        .w(w), .aw(aw), .fd_ready(fd_ready), .w_fire(w_fire)
    );

endmodule

/* src/rdmx_write_mux.sv */
// Write channel output mux
`include "rdmx_macros.svh"

module rdmx_write_mux (
    input  rdmx_pkg::rdmx_cfg_t     cfg,
    input  rdmx_pkg::rdmx_mode_e    mode,
    input  logic                    first_beat,
    input  logic [`RDMX_CNT_W-1:0]  frame_count,
    input  logic [`RDMX_ADDR_W-1:0] fd_off,
    input  logic [`RDMX_ADDR_W-1:0] md_off,
    input  logic                    md_full,
    input  logic [`RDMX_DATA_W-1:0] md_beat0,
    input  logic [`RDMX_DATA_W-1:0] md_beat1,
    input  logic [`RDMX_DATA_W-1:0] fd_data,
    input  logic                    fd_valid,
    input  logic                    fd_last,
    input  rdmx_pkg::rdmx_geom_t    geom,
    input  logic                    w_ready,
    output rdmx_pkg::rdmx_w_beat_t  w,
    output rdmx_pkg::rdmx_aw_t      aw,
    output logic                    fd_ready,
    output logic                    w_fire
);

    import rdmx_pkg::*;

    localparam logic [`RDMX_LEN_W-1:0] MD_LEN = 1;

    // Counter value that the frame being written will carry
    logic [`RDMX_CNT_W-1:0] fc_next;

    assign fc_next = frame_count + 1'b1;

    // ----------------------------------------
    // W channel
    // ----------------------------------------
    // Metadata waits for both beats to be held
    always_comb begin
        w = '0;
        case (mode)
            MODE_FD: begin
                w.data  = fd_data;
                w.strb  = '1;
                w.last  = fd_last;
                w.valid = fd_valid;
            end
            MODE_MD1: begin
                w.data  = md_beat0;
                w.strb  = '1;
                w.valid = md_full;
            end
            MODE_MD2: begin
                w.data  = md_beat1;
                w.strb  = '1;
                w.last  = 1'b1;
                w.valid = md_full;
            end
            MODE_FC: begin
                w.data  = {{(`RDMX_DATA_W - `RDMX_CNT_W){1'b0}}, fc_next};
                w.strb  = `RDMX_FC_STRB;
                w.last  = 1'b1;
                w.valid = 1'b1;
            end
            default: ;
        endcase
    end

    assign w_fire   = w.valid && w_ready;
    assign fd_ready = (mode == MODE_FD) && w_ready;

    // ----------------------------------------
    // AW channel
    // ----------------------------------------
    // Strobe on the first beat of each burst, md2 rides on md1's burst
    always_comb begin
        aw      = '0;
        aw.user = fc_next;
        case (mode)
            MODE_FD: begin
                aw.addr  = cfg.fd_ring_addr + fd_off;
                aw.len   = geom.beats_per_pkt - 1'b1;
                aw.valid = first_beat && w_fire;
            end
            MODE_MD1: begin
                aw.addr  = cfg.md_ring_addr + md_off;
                aw.len   = MD_LEN;
                aw.valid = first_beat && w_fire;
            end
            MODE_MD2: begin
                aw.addr = cfg.md_ring_addr + md_off;
                aw.len  = MD_LEN;
            end
            MODE_FC: begin
                aw.addr  = cfg.fc_addr;
                aw.valid = first_beat && w_fire;
            end
            default: ;
        endcase
    end

endmodule

/* src/rdmx_ring_ptrs.sv */
// Ring buffer offsets
`include "rdmx_macros.svh"

module rdmx_ring_ptrs (
    input  logic                    clk,
    input  logic                    resetn,
    input  rdmx_pkg::rdmx_cfg_t     cfg,
    input  logic                    pkt_done,
    input  logic                    md_done,
    output logic [`RDMX_ADDR_W-1:0] fd_off,
    output logic [`RDMX_ADDR_W-1:0] md_off
);

    localparam logic [`RDMX_ADDR_W-1:0] MD_STEP = `RDMX_MD_BYTES;

    logic [`RDMX_ADDR_W-1:0] fd_step;
    logic [`RDMX_ADDR_W-1:0] fd_next;
    logic [`RDMX_ADDR_W-1:0] md_next;

    // Frame data moves by one packet
    assign fd_step = {{(`RDMX_ADDR_W - 16){1'b0}}, cfg.pkt_size};
    assign fd_next = fd_off + fd_step;

    // Metadata moves by one record
    assign md_next = md_off + MD_STEP;

    // ----------------------------------------
    // Frame-data ring
    // ----------------------------------------
    // Wrap when the next packet would not fit
    always_ff @(posedge clk) begin
        if (!resetn) begin
            fd_off <= '0;
        end else if (pkt_done) begin
            fd_off <= (fd_next < cfg.fd_ring_size) ? fd_next : '0;
        end
    end

    // ----------------------------------------
    // Metadata ring
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            md_off <= '0;
        end else if (md_done) begin
            md_off <= (md_next < cfg.md_ring_size) ? md_next : '0;
        end
    end

endmodule

/* src/rdmx_frame_sequencer.sv */
// Frame sequencer FSM
`include "rdmx_macros.svh"

module rdmx_frame_sequencer (
    input  logic                   clk,
    input  logic                   resetn,
    input  rdmx_pkg::rdmx_geom_t   geom,
    input  logic                   w_fire,
    input  logic                   w_last,
    input  logic                   md_full,
    output rdmx_pkg::rdmx_mode_e   mode,
    output logic                   first_beat,
    output logic                   md_release,
    output logic                   pkt_done,
    output logic                   md_done,
    output logic [`RDMX_CNT_W-1:0] frame_count
);

    import rdmx_pkg::*;

    localparam logic [`RDMX_CNT_W-1:0] FIRST_PKT   = 1;
    localparam logic [`RDMX_LEN_W-1:0] SECOND_BEAT = 1;

    rdmx_seq_state_e        state;
    logic [`RDMX_LEN_W-1:0] beat;
    logic [`RDMX_CNT_W-1:0] pkt_count;
    logic                   last_pkt;

    // Packet count starts at one
    assign last_pkt = (pkt_count == geom.pkts_per_half);

    // Output mode follows the state directly
    always_comb begin
        case (state)
            ST_XFER_PACKET: mode = MODE_FD;
            ST_OUTPUT_MD1:  mode = MODE_MD1;
            ST_OUTPUT_MD2:  mode = MODE_MD2;
            ST_OUTPUT_FC:   mode = MODE_FC;
            default:        mode = MODE_IDLE;
        endcase
    end

    assign first_beat = (beat == '0);

    // Ring pointer step pulses
    assign pkt_done = (state == ST_XFER_PACKET) && w_fire && w_last;
    assign md_done  = (state == ST_OUTPUT_MD2) && w_fire;

    // First release opens the capture buffer after reset
    // Later releases come once the record has gone out
    assign md_release = md_full && ((state == ST_START) || md_done);

    // ----------------------------------------
    // Main frame FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state       <= ST_RESET;
            beat        <= '0;
            pkt_count   <= FIRST_PKT;
            frame_count <= '0;
        end else begin
            case (state)
                ST_RESET: state <= ST_START;

                ST_START: begin
                    beat      <= '0;
                    pkt_count <= FIRST_PKT;
                    state     <= ST_XFER_PACKET;
                end

                // Count beats and packets of the half-frame
                ST_XFER_PACKET: if (w_fire) begin
                    if (w_last) begin
                        beat <= '0;
                        if (last_pkt) state <= ST_OUTPUT_MD1;
                        else pkt_count <= pkt_count + 1'b1;
                    end else begin
                        beat <= beat + 1'b1;
                    end
                end

                // First half of the record, opens the burst
                ST_OUTPUT_MD1: if (w_fire) begin
                    beat  <= SECOND_BEAT;
                    state <= ST_OUTPUT_MD2;
                end

                // Second half, same burst
                ST_OUTPUT_MD2: if (w_fire) begin
                    beat  <= '0;
                    state <= ST_OUTPUT_FC;
                end

                // Counter beat closes the frame
                ST_OUTPUT_FC: if (w_fire) begin
                    frame_count <= frame_count + 1'b1;
                    pkt_count   <= FIRST_PKT;
                    state       <= ST_XFER_PACKET;
                end

                default: state <= ST_RESET;
            endcase
        end
    end

    // Stream last flag must close a packet of the length sent on aw.len
    a_pkt_len_on_last : assert property (@(posedge clk) disable iff (!resetn)
        (state == ST_XFER_PACKET) && w_fire && w_last |-> (beat == geom.beats_per_pkt - 1'b1))
        else $error("packet last beat does not match the decoded packet length");

endmodule

/* src/rdmx_md_capture.sv */
// Metadata two-beat capture
`include "rdmx_macros.svh"

module rdmx_md_capture (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic [`RDMX_DATA_W-1:0] md_data,
    input  logic                    md_valid,
    output logic                    md_ready,
    input  logic                    md_release,
    output logic [`RDMX_DATA_W-1:0] md_beat0,
    output logic [`RDMX_DATA_W-1:0] md_beat1,
    output logic                    md_full
);

    typedef enum logic [1:0] {
        CAP_EMPTY,
        CAP_ONE,
        CAP_FULL
    } cap_state_e;

    cap_state_e state;
    logic       md_take;

    // Accept input in the two filling states
    assign md_ready = (state != CAP_FULL);
    assign md_full  = (state == CAP_FULL);
    assign md_take  = md_valid && md_ready;

    // ----------------------------------------
    // Capture FSM
    // ----------------------------------------
    // Leaves reset closed, the sequencer opens it from its start state
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= CAP_FULL;
        end else begin
            case (state)
                CAP_EMPTY: if (md_take) state <= CAP_ONE;
                CAP_ONE:   if (md_take) state <= CAP_FULL;
                CAP_FULL:  if (md_release) state <= CAP_EMPTY;
                default:   state <= CAP_FULL;
            endcase
        end
    end

    // Record storage
    always_ff @(posedge clk) begin
        if (md_take && state == CAP_EMPTY) md_beat0 <= md_data;
        if (md_take && state == CAP_ONE)   md_beat1 <= md_data;
    end

    // Sequencer must only hand back a buffer it was given
    a_release_when_full : assert property (@(posedge clk) disable iff (!resetn)
        md_release |-> md_full)
        else $error("md_release while metadata buffer not full");

endmodule

/* src/rdmx_geometry.sv */
// Packet geometry decode
`include "rdmx_macros.svh"

module rdmx_geometry (
    input  logic                 clk,
    input  logic                 resetn,
    input  rdmx_pkg::rdmx_cfg_t  cfg,
    output rdmx_pkg::rdmx_geom_t geom
);

    // Full-width quotient, only the low bits reach the len field
    logic [15:0]            beats_full;
    logic [`RDMX_CNT_W-1:0] pkts_per_frame;

    assign beats_full = cfg.pkt_size / 16'(`RDMX_STRB_W);

    // Only power-of-two sizes are legal
    // Anything else is treated as a single packet per frame
    always_comb begin
        case (cfg.pkt_size)
            16'd64:   pkts_per_frame = cfg.frame_size >> 6;
            16'd128:  pkts_per_frame = cfg.frame_size >> 7;
            16'd256:  pkts_per_frame = cfg.frame_size >> 8;
            16'd512:  pkts_per_frame = cfg.frame_size >> 9;
            16'd1024: pkts_per_frame = cfg.frame_size >> 10;
            16'd2048: pkts_per_frame = cfg.frame_size >> 11;
            16'd4096: pkts_per_frame = cfg.frame_size >> 12;
            16'd8192: pkts_per_frame = cfg.frame_size >> 13;
            default:  pkts_per_frame = 1;
        endcase
    end

    // This shim only sees half of each frame
    // The other half goes to a sibling instance
    always_ff @(posedge clk) begin
        if (!resetn) begin
            geom <= '0;
        end else begin
            geom.beats_per_pkt <= beats_full[`RDMX_LEN_W-1:0];
            geom.pkts_per_half <= pkts_per_frame >> 1;
        end
    end

endmodule

/* src/rdmx_pkg.sv */
// RDMA write shim types
`include "rdmx_macros.svh"

package rdmx_pkg;

    // Static configuration, held steady while out of reset
    typedef struct packed {
        logic [15:0]              pkt_size;
        logic [31:0]              frame_size;
        logic [`RDMX_ADDR_W-1:0]  fd_ring_addr;
        logic [`RDMX_ADDR_W-1:0]  fd_ring_size;
        logic [`RDMX_ADDR_W-1:0]  md_ring_addr;
        logic [`RDMX_ADDR_W-1:0]  md_ring_size;
        logic [`RDMX_ADDR_W-1:0]  fc_addr;
    } rdmx_cfg_t;

    // One write-data beat
    typedef struct packed {
        logic [`RDMX_DATA_W-1:0]  data;
        logic [`RDMX_STRB_W-1:0]  strb;
        logic                     last;
        logic                     valid;
    } rdmx_w_beat_t;

    // Write-address strobe, no ready
    typedef struct packed {
        logic [`RDMX_ADDR_W-1:0]  addr;
        logic [`RDMX_LEN_W-1:0]   len;
        logic [`RDMX_CNT_W-1:0]   user;
        logic                     valid;
    } rdmx_aw_t;

    // Decoded packet geometry
    typedef struct packed {
        logic [`RDMX_LEN_W-1:0]   beats_per_pkt;
        logic [`RDMX_CNT_W-1:0]   pkts_per_half;
    } rdmx_geom_t;

    // What the write channels are carrying
    typedef enum logic [2:0] {
        MODE_IDLE,
        MODE_FD,
        MODE_MD1,
        MODE_MD2,
        MODE_FC
    } rdmx_mode_e;

    // Main frame FSM
    typedef enum logic [2:0] {
        ST_RESET,
        ST_START,
        ST_XFER_PACKET,
        ST_OUTPUT_MD1,
        ST_OUTPUT_MD2,
        ST_OUTPUT_FC
    } rdmx_seq_state_e;

endpackage

/* src/rdmx_macros.svh */
// RDMA write shim widths
`ifndef RDMX_MACROS_SVH
`define RDMX_MACROS_SVH

// Width of the stream and write-data buses
`define RDMX_DATA_W 512

// One strobe bit per data byte
`define RDMX_STRB_W (`RDMX_DATA_W / 8)

// Remote memory address width
`define RDMX_ADDR_W 64

// Burst length field, also beats per packet
`define RDMX_LEN_W 8

// Frame counter, packet counter and aw user field
`define RDMX_CNT_W 32

// Size of one metadata record, two beats at 512 bits
`define RDMX_MD_BYTES 128

// Frame counter is 4 bytes wide, so only the low strobes are set
`define RDMX_FC_STRB {{(`RDMX_STRB_W - 4){1'b0}}, 4'hF}

`endif
